// File: project.f
+incdir+hw
hw/pfir_pkg.sv
hw/pfir_sample_aligner.sv
hw/pfir_coef_bank.sv
hw/pfir_tap_chain.sv
hw/pfir_pole_fir.sv
bench/pfir_checker.sv
bench/pfir_tb.sv

// File: Bender.yml
package:
  name: pfir

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/pfir_pkg.sv
      - hw/pfir_sample_aligner.sv
      - hw/pfir_coef_bank.sv
      - hw/pfir_tap_chain.sv
      - hw/pfir_pole_fir.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/pfir_checker.sv
      - bench/pfir_tb.sv

// File: bench/pfir_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "pfir_params.svh"

// Testbench for pfir_pole_fir
// Random vectors every clock with coefficient traffic in phases
module pfir_tb;

    import pfir_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYC    = 10;
    localparam int NSAMP      = `PFIR_NSAMP;
    localparam int LAT        = `PFIR_LATENCY;
    localparam int F_TAPS     = `PFIR_F_TAPS;
    localparam int G_TAPS     = `PFIR_G_TAPS;
    localparam int RUN_CYC    = 3 * LAT;
    localparam int GAP_CYC    = LAT + 4;
    localparam int MIX_WR     = F_TAPS + G_TAPS;
    localparam int ROUNDS     = 2;

    // Cycle budget per phase
    localparam int ZERO_CYC   = 2 * LAT;
    localparam int SHADOW_CYC = MIX_WR + 2 * LAT;
    localparam int FULL_CYC   = 1 + RUN_CYC + ROUNDS * (MIX_WR + 4 + 1 + RUN_CYC);
    localparam int BANK_CYC   = 2 * GAP_CYC + (G_TAPS + 1 + RUN_CYC) + (F_TAPS + 1 + RUN_CYC);
    localparam int TOTAL_CYC  = RST_CYC + ZERO_CYC + RUN_CYC + SHADOW_CYC + FULL_CYC
                                + BANK_CYC + 2;
    localparam int WATCHDOG_CYC = TOTAL_CYC + 4 * LAT;

    // Phase codes seen by the checker
    localparam int PH_IDLE = 0, PH_RESET = 1, PH_UNIT = 2, PH_SHADOW = 3;
    localparam int PH_FULL = 4, PH_BANK_G = 5, PH_BANK_F = 6;

    logic        clk;
    logic        rst;
    logic        coeff_adr;
    logic        coeff_wr;
    logic        coeff_update;
    coef_t       coeff_dat;
    sample_vec_t dat;
    acc_t        f;
    acc_t        g;
    sample_vec_t x;
    int          phase;
    int          cur_phase;
    int          seed;
    int          err_total;

    always #(CLK_PERIOD / 2) clk = ~clk;

    pfir_pole_fir dut_i (
        .clk            (clk),
        .rst_i          (rst),
        .coeff_adr_i    (coeff_adr),
        .coeff_wr_i     (coeff_wr),
        .coeff_update_i (coeff_update),
        .coeff_dat_i    (coeff_dat),
        .dat_i          (dat),
        .f_o            (f),
        .g_o            (g),
        .x_o            (x)
    );

    pfir_checker u_checker (
        .clk            (clk),
        .rst_i          (rst),
        .phase_i        (phase),
        .coeff_adr_i    (coeff_adr),
        .coeff_wr_i     (coeff_wr),
        .coeff_update_i (coeff_update),
        .coeff_dat_i    (coeff_dat),
        .dat_i          (dat),
        .f_i            (f),
        .g_i            (g),
        .x_i            (x)
    );

    function automatic sample_vec_t rand_vec();
        sample_vec_t v;
        for (int s = 0; s < NSAMP; s++) begin
            v[s] = sample_t'($random(seed));
        end
        return v;
    endfunction

    // n clocks of fresh samples without coefficient traffic
    task automatic drive_samples(input int n, input logic zero);
        repeat (n) begin
            @(posedge clk);
            phase        <= cur_phase;
            dat          <= zero ? '0 : rand_vec();
            coeff_wr     <= 1'b0;
            coeff_update <= 1'b0;
        end
    endtask

    task automatic write_coef(input logic adr);
        @(posedge clk);
        phase        <= cur_phase;
        dat          <= rand_vec();
        coeff_wr     <= 1'b1;
        coeff_adr    <= adr;
        coeff_dat    <= coef_t'($random(seed));
        coeff_update <= 1'b0;
    endtask

    // Writes with the bank picked at random
    task automatic write_mixed(input int n);
        logic adr;
        repeat (n) begin
            adr = 1'($random(seed));
            write_coef(adr);
        end
    endtask

    task automatic pulse_update();
        @(posedge clk);
        phase        <= cur_phase;
        dat          <= rand_vec();
        coeff_wr     <= 1'b0;
        coeff_update <= 1'b1;
    endtask

    initial begin
        seed         = 32'h7fd3e633;
        clk          = 1'b0;
        rst          = 1'b1;
        coeff_adr    = 1'b0;
        coeff_wr     = 1'b0;
        coeff_update = 1'b0;
        coeff_dat    = '0;
        dat          = '0;
        phase        = PH_RESET;
        cur_phase    = PH_RESET;

        repeat (RST_CYC) @(posedge clk);
        rst <= 1'b0;

        // Zero input flushes through a cleared pipeline
        drive_samples(ZERO_CYC, 1'b1);
        cur_phase = PH_UNIT;
        drive_samples(RUN_CYC, 1'b0);

        // Shadow fills while active banks stay zero
        cur_phase = PH_SHADOW;
        write_mixed(MIX_WR);
        drive_samples(2 * LAT, 1'b0);

        cur_phase = PH_FULL;
        pulse_update();
        drive_samples(RUN_CYC, 1'b0);
        repeat (ROUNDS) begin
            write_mixed(MIX_WR);
            drive_samples(4, 1'b0);
            pulse_update();
            drive_samples(RUN_CYC, 1'b0);
        end

        // One bank at a time while the other must not move
        cur_phase = PH_IDLE;
        drive_samples(GAP_CYC, 1'b0);
        cur_phase = PH_BANK_G;
        repeat (G_TAPS) write_coef(1'b1);
        pulse_update();
        drive_samples(RUN_CYC, 1'b0);
        cur_phase = PH_IDLE;
        drive_samples(GAP_CYC, 1'b0);
        cur_phase = PH_BANK_F;
        repeat (F_TAPS) write_coef(1'b0);
        pulse_update();
        drive_samples(RUN_CYC, 1'b0);

        cur_phase = PH_IDLE;
        drive_samples(2, 1'b0);
        @(negedge clk);
        u_checker.report_counts(err_total);
        if (err_total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the phase budget
    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("ERROR: run timed out after %0d cycles", WATCHDOG_CYC);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/pfir_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "pfir_params.svh"

// Reference model and scoreboard for pfir_pole_fir
// Watches the DUT ports only and compares on every clock
module pfir_checker (
    input  logic                  clk,
    input  logic                  rst_i,
    input  int                    phase_i,
    input  logic                  coeff_adr_i,
    input  logic                  coeff_wr_i,
    input  logic                  coeff_update_i,
    input  pfir_pkg::coef_t       coeff_dat_i,
    input  pfir_pkg::sample_vec_t dat_i,
    input  pfir_pkg::acc_t        f_i,
    input  pfir_pkg::acc_t        g_i,
    input  pfir_pkg::sample_vec_t x_i
);

    import pfir_pkg::*;

    localparam int NSAMP  = `PFIR_NSAMP;
    localparam int LAT    = `PFIR_LATENCY;
    localparam int F_TAPS = `PFIR_F_TAPS;
    localparam int G_TAPS = `PFIR_G_TAPS;
    localparam int NTEST  = 6;
    localparam acc_t UNIT_GAIN = acc_t'(1) <<< `PFIR_COEF_FRAC;

    // Test ids used as counter index
    localparam int T_RESET = 0, T_DELAY = 1, T_UNIT = 2;
    localparam int T_SHADOW = 3, T_FULL = 4, T_BANK = 5;
    // Phase codes from the bench
    localparam int PH_RESET = 1, PH_UNIT = 2, PH_SHADOW = 3;
    localparam int PH_FULL = 4, PH_BANK_G = 5, PH_BANK_F = 6;

    string names [NTEST] = '{"reset_zero", "delay_line", "unit_only",
                             "shadow_hold", "full_sum", "bank_select"};

    // hist[i] is the vector that arrived i clocks ago
    sample_vec_t hist [LAT+2];
    // Tap k sits at index k and the newest write at the top index
    coef_t [F_TAPS-1:0] sh_f, act_f, snap_f;
    coef_t [G_TAPS-1:0] sh_g, act_g, snap_g;
    // Strobes and data pass one register in the top before a bank sees them
    logic  wr_f_q, wr_g_q, upd_q;
    coef_t dat_q;
    acc_t  exp_f, exp_g;
    logic  stable;
    int    cyc, act_chg, prev_phase;
    int    n_chk [NTEST];
    int    n_err [NTEST];

    initial begin
        for (int t = 0; t < NTEST; t++) begin
            n_chk[t] = 0;
            n_err[t] = 0;
        end
    end

    // f = u[0]*2^14 + sum C[k]*p[k+2]
    function automatic acc_t f_model(sample_vec_t u, sample_vec_t p, coef_t [F_TAPS-1:0] c);
        acc_t sum;
        sum = acc_t'($signed(u[0])) * UNIT_GAIN;
        for (int k = 0; k < F_TAPS; k++) begin
            sum += acc_t'($signed(c[k])) * acc_t'($signed(p[k+2]));
        end
        return sum;
    endfunction

    // g = u[1]*2^14 + D[0]*u[0] + sum D[k]*p[k+1]
    function automatic acc_t g_model(sample_vec_t u, sample_vec_t p, coef_t [G_TAPS-1:0] d);
        acc_t sum;
        sum = acc_t'($signed(u[1])) * UNIT_GAIN;
        sum += acc_t'($signed(d[0])) * acc_t'($signed(u[0]));
        for (int k = 1; k < G_TAPS; k++) begin
            sum += acc_t'($signed(d[k])) * acc_t'($signed(p[k+1]));
        end
        return sum;
    endfunction

    task automatic check_val(input int t, input string what, input acc_t exp, input acc_t act);
        n_chk[t]++;
        if (act !== exp) begin
            $display("FAIL %s cycle %0d %s expected %0d actual %0d",
                     names[t], cyc, what, exp, act);
            n_err[t]++;
        end
    endtask

    always @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < LAT+2; i++) begin
                hist[i] = '0;
            end
            sh_f = '0;
            act_f = '0;
            sh_g = '0;
            act_g = '0;
            wr_f_q = 1'b0;
            wr_g_q = 1'b0;
            upd_q = 1'b0;
            cyc = 0;
            // Zero banks out of reset count as long settled
            act_chg = -2 * LAT;
            prev_phase = phase_i;
        end else begin
            for (int i = LAT+1; i > 0; i--) begin
                hist[i] = hist[i-1];
            end
            hist[0] = dat_i;
            // Frozen banks for bank_select
            if (phase_i != prev_phase) begin
                snap_f = act_f;
                snap_g = act_g;
            end
            prev_phase = phase_i;

            // Sample s leaves s clocks late and samples 0 and 1 leave at once
            for (int s = 0; s < NSAMP; s++) begin
                check_val(T_DELAY, $sformatf("x_o[%0d]", s),
                          acc_t'($signed(hist[s < 2 ? 0 : s][s])), acc_t'($signed(x_i[s])));
            end

            // u arrived LAT clocks ago and p one clock before it
            exp_f = f_model(hist[LAT], hist[LAT+1], act_f);
            exp_g = g_model(hist[LAT], hist[LAT+1], act_g);
            // Banks must have held still over the whole flight of u and p
            stable = (cyc - act_chg) > LAT;

            case (phase_i)
                PH_RESET: begin
                    check_val(T_RESET, "f_o", '0, f_i);
                    check_val(T_RESET, "g_o", '0, g_i);
                    for (int s = 0; s < NSAMP; s++) begin
                        check_val(T_RESET, $sformatf("x_o[%0d]", s), '0, acc_t'($signed(x_i[s])));
                    end
                end
                PH_UNIT: begin
                    if (stable) begin
                        check_val(T_UNIT, "f_o", acc_t'($signed(hist[LAT][0])) * UNIT_GAIN, f_i);
                        check_val(T_UNIT, "g_o", acc_t'($signed(hist[LAT][1])) * UNIT_GAIN, g_i);
                    end
                end
                PH_SHADOW: begin
                    if (stable) begin
                        check_val(T_SHADOW, "f_o", exp_f, f_i);
                        check_val(T_SHADOW, "g_o", exp_g, g_i);
                    end
                end
                PH_FULL: begin
                    if (stable) begin
                        check_val(T_FULL, "f_o", exp_f, f_i);
                        check_val(T_FULL, "g_o", exp_g, g_i);
                    end
                end
                PH_BANK_G: begin
                    // Only g traffic here so f keeps its frozen bank
                    check_val(T_BANK, "f_o", f_model(hist[LAT], hist[LAT+1], snap_f), f_i);
                    if (stable) begin
                        check_val(T_BANK, "g_o", exp_g, g_i);
                    end
                end
                PH_BANK_F: begin
                    check_val(T_BANK, "g_o", g_model(hist[LAT], hist[LAT+1], snap_g), g_i);
                    if (stable) begin
                        check_val(T_BANK, "f_o", exp_f, f_i);
                    end
                end
                default: ;
            endcase

            // Update copies the shadow as it was before a write in the same clock
            if (upd_q && (act_f != sh_f || act_g != sh_g)) begin
                act_chg = cyc;
            end
            if (upd_q) begin
                act_f = sh_f;
                act_g = sh_g;
            end
            if (wr_f_q) begin
                for (int k = 0; k < F_TAPS-1; k++) begin
                    sh_f[k] = sh_f[k+1];
                end
                sh_f[F_TAPS-1] = dat_q;
            end
            if (wr_g_q) begin
                for (int k = 0; k < G_TAPS-1; k++) begin
                    sh_g[k] = sh_g[k+1];
                end
                sh_g[G_TAPS-1] = dat_q;
            end
            wr_f_q = coeff_wr_i && !coeff_adr_i;
            wr_g_q = coeff_wr_i && coeff_adr_i;
            upd_q = coeff_update_i;
            dat_q = coeff_dat_i;
            cyc++;
        end
    end

    // Sums the per-test counters into one closing line
    // A test that made no comparisons is counted as failed
    task automatic report_counts(output int total_err);
        int total_chk;
        total_chk = 0;
        total_err = 0;
        for (int t = 0; t < NTEST; t++) begin
            if (n_chk[t] == 0) begin
                $display("ERROR: test %s made no comparisons", names[t]);
                n_err[t]++;
            end
            total_chk += n_chk[t];
            total_err += n_err[t];
        end
        $write("checks %0d errors %0d", total_chk, total_err);
        for (int t = 0; t < NTEST; t++) begin
            $write(" | %s %0d/%0d", names[t], n_chk[t], n_err[t]);
        end
        $write("\n");
    endtask

endmodule

`default_nettype wire

// File: hw/pfir_pole_fir.sv
`timescale 1ns/100ps
`default_nettype none

`include "pfir_params.svh"

// Compensating FIR for a biquad pole pair
//
//   f = u[0] + sum C[k] p[k+2]                 k = 0 .. NSAMP-3
//   g = u[1] + D[0] u[0] + sum D[k] p[k+1]     k = 1 .. NSAMP-2
//
// u is the current vector, p the vector one clock before it
// Both sums leave PFIR_LATENCY clocks after their vector
module pfir_pole_fir (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  coeff_adr_i,
    input  logic                  coeff_wr_i,
    input  logic                  coeff_update_i,
    input  pfir_pkg::coef_t       coeff_dat_i,
    input  pfir_pkg::sample_vec_t dat_i,
    output pfir_pkg::acc_t        f_o,
    output pfir_pkg::acc_t        g_o,
    output pfir_pkg::sample_vec_t x_o
);

    import pfir_pkg::*;

    localparam int F_TAPS = `PFIR_F_TAPS;
    localparam int G_TAPS = `PFIR_G_TAPS;

    logic  wr_f_q;
    logic  wr_g_q;
    logic  update_q;
    coef_t coef_dat_q;

    coef_t [F_TAPS-1:0] f_coef;
    coef_t [G_TAPS-1:0] g_coef;

    wire sample_t [F_TAPS-1:0] f_taps;
    wire sample_t [G_TAPS-1:0] g_taps;

    // Address 0 selects the f bank, 1 the g bank
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_f_q   <= 1'b0;
            wr_g_q   <= 1'b0;
            update_q <= 1'b0;
        end else begin
            wr_f_q   <= coeff_wr_i && !coeff_adr_i;
            wr_g_q   <= coeff_wr_i && coeff_adr_i;
            update_q <= coeff_update_i;
        end
    end

    // Write data travels alongside its strobe
    always_ff @(posedge clk) begin
        coef_dat_q <= coeff_dat_i;
    end

    pfir_sample_aligner u_aligner (
        .clk   (clk),
        .rst_i (rst_i),
        .dat_i (dat_i),
        .x_o   (x_o)
    );

    // f chain taps start at sample 2
    for (genvar k = 0; k < F_TAPS; k++) begin : g_f_taps
        assign f_taps[k] = x_o[k+2];
    end

    // g chain tap 0 is the undelayed sample 0, the rest start at sample 2
    assign g_taps[0] = x_o[0];
    for (genvar k = 1; k < G_TAPS; k++) begin : g_g_taps
        assign g_taps[k] = x_o[k+1];
    end

    pfir_coef_bank #(.NTAPS(F_TAPS)) u_f_bank (
        .clk      (clk),
        .rst_i    (rst_i),
        .wr_i     (wr_f_q),
        .update_i (update_q),
        .dat_i    (coef_dat_q),
        .coef_o   (f_coef)
    );

    pfir_coef_bank #(.NTAPS(G_TAPS)) u_g_bank (
        .clk      (clk),
        .rst_i    (rst_i),
        .wr_i     (wr_g_q),
        .update_i (update_q),
        .dat_i    (coef_dat_q),
        .coef_o   (g_coef)
    )

    ;

    // Shorter f chain takes one extra unit register to line up with g
    pfir_tap_chain #(.NTAPS(F_TAPS), .HEAD_PREV(1)) u_f_chain (
        .clk    (clk),
        .rst_i  (rst_i),
        .unit_i (x_o[0]),
        .taps_i (f_taps),
        .coef_i (f_coef),
        .acc_o  (f_o)
    );

    pfir_tap_chain #(.NTAPS(G_TAPS), .HEAD_PREV(0)) u_g_chain (
        .clk    (clk),
        .rst_i  (rst_i),
        .unit_i (x_o[1]),
        .taps_i (g_taps),
        .coef_i (g_coef),
        .acc_o  (g_o)
    );

endmodule

`default_nettype wire

// File: hw/pfir_tap_chain.sv
`timescale 1ns/100ps
`default_nettype none

`include "pfir_params.svh"

// Systolic multiply-accumulate cascade
//
// Stage k registers coef_i[k] * taps_i[k], then adds it to the partial sum
// handed over by stage k-1 on the next clock
// The head stage adds the unit term instead of an upstream sum
//
// Input to acc_o delays
//   taps_i[k]  NTAPS + 1 - k
//   unit_i     NTAPS + 1 + HEAD_PREV
// The caller skews taps_i so every term of one vector meets in the last stage
module pfir_tap_chain #(
    parameter int NTAPS     = 6,
    parameter int HEAD_PREV = 0
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  pfir_pkg::sample_t             unit_i,
    input  pfir_pkg::sample_t [NTAPS-1:0] taps_i,
    input  pfir_pkg::coef_t   [NTAPS-1:0] coef_i,
    output pfir_pkg::acc_t                acc_o
);

    import pfir_pkg::*;

    // Unit path registers, one base stage plus the optional extra one
    localparam int UNIT_DLY = HEAD_PREV + 1;

    sample_t unit_q [UNIT_DLY];
    acc_t    prod_q [NTAPS];
    acc_t    sum_q  [NTAPS];
    acc_t    unit_term;

    // Both chains must land on the same output cycle
    if (NTAPS + 1 + HEAD_PREV != `PFIR_LATENCY) begin : g_len_check
        $error("pfir_tap_chain: unit path latency does not match PFIR_LATENCY");
    end

    // Unit gain term
    // Sign extend first, then shift into the coefficient fraction position
    assign unit_term = acc_t'(unit_q[UNIT_DLY-1]) <<< `PFIR_COEF_FRAC;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < UNIT_DLY; i++) begin
                unit_q[i] <= '0;
            end
            for (int k = 0; k < NTAPS; k++) begin
                prod_q[k] <= '0;
                sum_q[k]  <= '0;
            end
        end else begin
            unit_q[0] <= unit_i;
            // Extra head register, only present for the f chain
            for (int i = 1; i < UNIT_DLY; i++) begin
                unit_q[i] <= unit_q[i-1];
            end

            // Product registers
            // Operands are signed, so they widen to 48 bits before multiplying
            for (int k = 0; k < NTAPS; k++) begin
                prod_q[k] <= coef_i[k] * taps_i[k];
            end

            // Head adds the unit term
            sum_q[0] <= unit_term + prod_q[0];

            // Cascade, one stage per clock
            for (int k = 1; k < NTAPS; k++) begin
                sum_q[k] <= sum_q[k-1] + prod_q[k];
            end
        end
    end

    // Last partial sum holds every term of one vector
    assign acc_o = sum_q[NTAPS-1];

    // The whole pipeline is cleared by reset and fed only by known ports
    assert property (@(posedge clk) disable iff (rst_i)
        !$isunknown(acc_o))
    else $error("tap_chain: unknown bits on acc_o");

endmodule

`default_nettype wire

// File: hw/pfir_coef_bank.sv
`timescale 1ns/100ps
`default_nettype none

// Double-buffered coefficient store for one tap chain
// Writes shift into a shadow chain, an update copies shadow to active
// Only the active words ever reach the multipliers
module pfir_coef_bank #(
    parameter int NTAPS = 6
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          wr_i,
    input  logic                          update_i,
    input  pfir_pkg::coef_t               dat_i,
    output pfir_pkg::coef_t [NTAPS-1:0]   coef_o
);

    import pfir_pkg::*;

    // Position 0 holds the newest write, NTAPS-1 the oldest
    coef_t shadow_q [NTAPS];
    coef_t active_q [NTAPS];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < NTAPS; i++) begin
                shadow_q[i] <= '0;
                active_q[i] <= '0;
            end
        end else begin
            if (wr_i) begin
                shadow_q[0] <= dat_i;
                // Oldest word drops off the end
                for (int i = 1; i < NTAPS; i++) begin
                    shadow_q[i] <= shadow_q[i-1];
                end
            end
            // Write and update together: active gets the pre-write shadow
            if (update_i) begin
                active_q <= shadow_q;
            end
        end
    end

    // Tap 0 takes the oldest word, the last tap the newest
    always_comb begin
        for (int k = 0; k < NTAPS; k++) begin
            coef_o[k] = active_q[NTAPS-1-k];
        end
    end

    // Shadow writes must never leak into the multipliers on their own
    assert property (@(posedge clk) disable iff (rst_i)
        (!$past(update_i) && !$past(rst_i)) |-> $stable(coef_o))
    else $error("coef_bank: active coefficients changed without update");

endmodule

`default_nettype wire

// File: hw/pfir_sample_aligner.sv
`timescale 1ns/100ps
`default_nettype none

`include "pfir_params.svh"

// Staggers the input vector so that sample s leaves s cycles late
// Samples 0 and 1 go straight through
// The staggered copies are shared by both tap chains and also leave on x_o
module pfir_sample_aligner (
    input  logic                  clk,
    input  logic                  rst_i,
    input  pfir_pkg::sample_vec_t dat_i,
    output wire pfir_pkg::sample_vec_t x_o
);

    import pfir_pkg::*;

    localparam int NSAMP = `PFIR_NSAMP;

    for (genvar s = 0; s < NSAMP; s++) begin : g_smp
        if (s < 2) begin : g_pass
            // Head samples need no alignment
            assign x_o[s] = dat_i[s];
        end else begin : g_dly
            // Plain register line, depth equals the sample index
            sample_t dly_q [s];

            always_ff @(posedge clk) begin
                if (rst_i) begin
                    for (int i = 0; i < s; i++) begin
                        dly_q[i] <= '0;
                    end
                end else begin
                    dly_q[0] <= dat_i[s];
                    // Each stage hands its word one step deeper
                    for (int i = 1; i < s; i++) begin
                        dly_q[i] <= dly_q[i-1];
                    end
                end
            end

            // Deepest stage is the aligned sample
            assign x_o[s] = dly_q[s-1];
        end
    end

    // Sample 2 is the first delayed lane and feeds the head of the f chain
    // Its output must be the input from two clocks back once reset has flushed
    assert property (@(posedge clk) disable iff (rst_i)
        (!$past(rst_i) && !$past(rst_i, 2)) |-> (x_o[2] == $past(dat_i[2], 2)))
    else $error("aligner: sample 2 delay mismatch");

endmodule

`default_nettype wire

// File: hw/pfir_pkg.sv
`default_nettype none

`include "pfir_params.svh"

package pfir_pkg;

    // One signed input sample
    typedef logic signed [`PFIR_SAMPLE_W-1:0] sample_t;

    // Whole input vector
    // Element 0 is the oldest sample in time, NSAMP-1 the newest
    typedef sample_t [`PFIR_NSAMP-1:0] sample_vec_t;

    // One signed FIR coefficient
    typedef logic signed [`PFIR_COEF_W-1:0] coef_t;

    // Partial sums and products
    // Wide enough for every product plus the unit term, no saturation
    typedef logic signed [`PFIR_ACC_W-1:0] acc_t;

endpackage

`default_nettype wire

// File: hw/pfir_params.svh
`ifndef PFIR_PARAMS_SVH
`define PFIR_PARAMS_SVH

// Samples carried by one input vector, one vector per clock
`define PFIR_NSAMP 8

// Sample format, signed with 2 fraction bits
`define PFIR_SAMPLE_W 16
`define PFIR_SAMPLE_FRAC 2

// Coefficient format, signed with 14 fraction bits
// Unit terms get shifted up by COEF_FRAC to line up with products
`define PFIR_COEF_W 18
`define PFIR_COEF_FRAC 14

// Accumulator width, matches a 48 bit DSP post-adder
`define PFIR_ACC_W 48

// Chain lengths
`define PFIR_F_TAPS (`PFIR_NSAMP - 2)
`define PFIR_G_TAPS (`PFIR_NSAMP - 1)

// Cycles from a vector on dat_i to its f/g sums
`define PFIR_LATENCY `PFIR_NSAMP

`endif
